// ==== hw/id_settings.svh ====
`ifndef ID_SETTINGS_SVH
`define ID_SETTINGS_SVH

// datapath and address width
`define ID_XLEN 32

// architectural register file
`define ID_NREGS 32
`define ID_REG_AW 5

// destination of jal
`define ID_LINK_REG 31

`endif

// ==== hw/isa_pkg.sv ====
`include "id_settings.svh"

package isa_pkg;

    typedef logic [`ID_XLEN-1:0] word_t;
    typedef logic [`ID_REG_AW-1:0] reg_idx_t;
    typedef logic [15:0] imm16_t;
    typedef logic [25:0] jidx_t;

    // primary opcode field, inst[31:26]
    typedef enum logic [5:0] {
        OP_SPECIAL = 6'h00,
        OP_J       = 6'h02,
        OP_JAL     = 6'h03,
        OP_BEQ     = 6'h04,
        OP_BNE     = 6'h05,
        OP_ADDIU   = 6'h09,
        OP_SLTI    = 6'h0a,
        OP_SLTIU   = 6'h0b,
        OP_ANDI    = 6'h0c,
        OP_ORI     = 6'h0d,
        OP_XORI    = 6'h0e,
        OP_LUI     = 6'h0f,
        OP_LW      = 6'h23,
        OP_SW      = 6'h2b
    } opcode_e;

    // function field of special, inst[5:0]
    typedef enum logic [5:0] {
        F_SLL  = 6'h00,
        F_SRL  = 6'h02,
        F_SRA  = 6'h03,
        F_JR   = 6'h08,
        F_ADDU = 6'h21,
        F_SUBU = 6'h23,
        F_AND  = 6'h24,
        F_OR   = 6'h25,
        F_XOR  = 6'h26,
        F_NOR  = 6'h27,
        F_SLT  = 6'h2a,
        F_SLTU = 6'h2b
    } funct_e;

endpackage

// ==== hw/ctrl_pkg.sv ====
package ctrl_pkg;

    localparam int ALU_OP_W  = 4;
    localparam int SEL_W     = 2;
    localparam int BR_KIND_W = 3;

    typedef enum logic [ALU_OP_W-1:0] {
        ALU_ADD, ALU_SUB, ALU_SLT, ALU_SLTU,
        ALU_AND, ALU_NOR, ALU_OR, ALU_XOR,
        ALU_SLL, ALU_SRL, ALU_SRA, ALU_LUI
    } alu_op_e;

    // first ALU operand
    typedef enum logic [SEL_W-1:0] {
        SRC1_RS, SRC1_PC, SRC1_SA
    } src1_sel_e;

    // second ALU operand, eight is for the link address
    typedef enum logic [SEL_W-1:0] {
        SRC2_RT, SRC2_SIMM, SRC2_ZIMM, SRC2_EIGHT
    } src2_sel_e;

    typedef enum logic [BR_KIND_W-1:0] {
        BR_NONE, BR_BEQ, BR_BNE, BR_JUMP, BR_JR
    } br_kind_e;

endpackage

// ==== hw/fetch_decode_reg.sv ====
module fetch_decode_reg (
    input  logic          clk,
    input  logic          rst,
    input  logic          hold_id,
    input  logic          bubble_id,
    input  logic          fetch_valid,
    input  isa_pkg::word_t fetch_pc,
    input  isa_pkg::word_t inst_rdata,
    output logic          id_valid,
    output isa_pkg::word_t id_pc,
    output isa_pkg::word_t id_inst
);

    logic           held_q;
    isa_pkg::word_t inst_hold_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            id_valid <= 1'b0;
            held_q   <= 1'b0;
        end else if (hold_id) begin
            held_q <= 1'b1;
        end else begin
            held_q   <= 1'b0;
            id_valid <= fetch_valid & ~bubble_id;
            id_pc    <= fetch_pc;
        end
    end

    // memory data moves on after the first held cycle, so keep a copy
    always_ff @(posedge clk) begin
        if (hold_id && !held_q) begin
            inst_hold_q <= inst_rdata;
        end
    end

    assign id_inst = held_q ? inst_hold_q : inst_rdata;

    a_no_hold_and_bubble: assert property (@(posedge clk) disable iff (rst)
        !(hold_id && bubble_id));

endmodule

// ==== hw/inst_decoder.sv ====
`include "id_settings.svh"

module inst_decoder (
    input  logic                 id_valid,
    input  isa_pkg::word_t       id_inst,
    output isa_pkg::reg_idx_t    rs,
    output isa_pkg::reg_idx_t    rt,
    output ctrl_pkg::alu_op_e    alu_op,
    output ctrl_pkg::src1_sel_e  src1_sel,
    output ctrl_pkg::src2_sel_e  src2_sel,
    output logic                 mem_en,
    output logic                 mem_we,
    output logic                 rf_we,
    output isa_pkg::reg_idx_t    rf_waddr,
    output ctrl_pkg::br_kind_e   br_kind,
    output logic                 uses_rs,
    output logic                 uses_rt
);

    isa_pkg::opcode_e  opcode;
    isa_pkg::funct_e   funct;
    isa_pkg::reg_idx_t rd;
    logic [4:0]        shamt;
    ctrl_pkg::alu_op_e fn_op;
    logic              fn_rr;
    logic              fn_shift;

    assign opcode = isa_pkg::opcode_e'(id_inst[31:26]);
    assign funct  = isa_pkg::funct_e'(id_inst[5:0]);
    assign rs     = id_inst[25:21];
    assign rt     = id_inst[20:16];
    assign rd     = id_inst[15:11];
    assign shamt  = id_inst[10:6];

    // special function table
    always_comb begin
        fn_op    = ctrl_pkg::ALU_ADD;
        fn_rr    = 1'b1;
        fn_shift = 1'b0;
        case (funct)
            isa_pkg::F_ADDU: fn_op = ctrl_pkg::ALU_ADD;
            isa_pkg::F_SUBU: fn_op = ctrl_pkg::ALU_SUB;
            isa_pkg::F_AND:  fn_op = ctrl_pkg::ALU_AND;
            isa_pkg::F_OR:   fn_op = ctrl_pkg::ALU_OR;
            isa_pkg::F_XOR:  fn_op = ctrl_pkg::ALU_XOR;
            isa_pkg::F_NOR:  fn_op = ctrl_pkg::ALU_NOR;
            isa_pkg::F_SLT:  fn_op = ctrl_pkg::ALU_SLT;
            isa_pkg::F_SLTU: fn_op = ctrl_pkg::ALU_SLTU;
            isa_pkg::F_SLL: begin
                fn_op    = ctrl_pkg::ALU_SLL;
                fn_rr    = 1'b0;
                fn_shift = 1'b1;
            end
            isa_pkg::F_SRL: begin
                fn_op    = ctrl_pkg::ALU_SRL;
                fn_rr    = 1'b0;
                fn_shift = 1'b1;
            end
            isa_pkg::F_SRA: begin
                fn_op    = ctrl_pkg::ALU_SRA;
                fn_rr    = 1'b0;
                fn_shift = 1'b1;
            end
            default: fn_rr = 1'b0;
        endcase
    end

    always_comb begin
        alu_op   = ctrl_pkg::ALU_ADD;
        src1_sel = ctrl_pkg::SRC1_RS;
        src2_sel = ctrl_pkg::SRC2_RT;
        mem_en   = 1'b0;
        mem_we   = 1'b0;
        rf_we    = 1'b0;
        rf_waddr = '0;
        br_kind  = ctrl_pkg::BR_NONE;
        uses_rs  = 1'b0;
        uses_rt  = 1'b0;
        if (id_valid) begin
            case (opcode)
                isa_pkg::OP_SPECIAL: begin
                    if (fn_rr && shamt == 5'd0) begin
                        alu_op   = fn_op;
                        rf_we    = 1'b1;
                        rf_waddr = rd;
                        uses_rs  = 1'b1;
                        uses_rt  = 1'b1;
                    end else if (fn_shift && rs == '0) begin
                        alu_op   = fn_op;
                        src1_sel = ctrl_pkg::SRC1_SA;
                        rf_we    = 1'b1;
                        rf_waddr = rd;
                        uses_rt  = 1'b1;
                    end else if (funct == isa_pkg::F_JR && id_inst[20:6] == '0) begin
                        br_kind = ctrl_pkg::BR_JR;
                        uses_rs = 1'b1;
                    end
                end
                isa_pkg::OP_ADDIU, isa_pkg::OP_SLTI, isa_pkg::OP_SLTIU, isa_pkg::OP_ANDI,
                isa_pkg::OP_ORI, isa_pkg::OP_XORI, isa_pkg::OP_LUI, isa_pkg::OP_LW: begin
                    rf_we    = 1'b1;
                    rf_waddr = rt;
                    uses_rs  = (opcode != isa_pkg::OP_LUI);
                    src2_sel = ctrl_pkg::SRC2_SIMM;
                    case (opcode)
                        isa_pkg::OP_SLTI:  alu_op = ctrl_pkg::ALU_SLT;
                        isa_pkg::OP_SLTIU: alu_op = ctrl_pkg::ALU_SLTU;
                        isa_pkg::OP_LUI:   alu_op = ctrl_pkg::ALU_LUI;
                        isa_pkg::OP_ANDI: begin
                            alu_op   = ctrl_pkg::ALU_AND;
                            src2_sel = ctrl_pkg::SRC2_ZIMM;
                        end
                        isa_pkg::OP_ORI: begin
                            alu_op   = ctrl_pkg::ALU_OR;
                            src2_sel = ctrl_pkg::SRC2_ZIMM;
                        end
                        isa_pkg::OP_XORI: begin
                            alu_op   = ctrl_pkg::ALU_XOR;
                            src2_sel = ctrl_pkg::SRC2_ZIMM;
                        end
                        default: alu_op = ctrl_pkg::ALU_ADD;
                    endcase
                    mem_en = (opcode == isa_pkg::OP_LW);
                end
                isa_pkg::OP_SW: begin
                    src2_sel = ctrl_pkg::SRC2_SIMM;
                    mem_en   = 1'b1;
                    mem_we   = 1'b1;
                    uses_rs  = 1'b1;
                    uses_rt  = 1'b1;
                end
                isa_pkg::OP_BEQ, isa_pkg::OP_BNE: begin
                    br_kind = (opcode == isa_pkg::OP_BEQ) ? ctrl_pkg::BR_BEQ : ctrl_pkg::BR_BNE;
                    uses_rs = 1'b1;
                    uses_rt = 1'b1;
                end
                isa_pkg::OP_J: br_kind = ctrl_pkg::BR_JUMP;
                isa_pkg::OP_JAL: begin
                    // link value is pc + 8 through the adder
                    br_kind  = ctrl_pkg::BR_JUMP;
                    src1_sel = ctrl_pkg::SRC1_PC;
                    src2_sel = ctrl_pkg::SRC2_EIGHT;
                    rf_we    = 1'b1;
                    rf_waddr = isa_pkg::reg_idx_t'(`ID_LINK_REG);
                end
                default: ;
            endcase
        end
    end

endmodule

// ==== hw/operand_fetch.sv ====
`include "id_settings.svh"

module operand_fetch (
    input  logic              clk,
    input  logic              rst,
    input  isa_pkg::reg_idx_t rs,
    input  isa_pkg::reg_idx_t rt,
    input  logic              uses_rs,
    input  logic              uses_rt,
    input  logic              id_valid,
    input  logic              wb_we,
    input  logic              ex_we,
    input  logic              mem_we,
    input  logic              ex_is_load,
    input  isa_pkg::reg_idx_t wb_waddr,
    input  isa_pkg::reg_idx_t ex_waddr,
    input  isa_pkg::reg_idx_t mem_waddr,
    input  isa_pkg::word_t    wb_wdata,
    input  isa_pkg::word_t    ex_wdata,
    input  isa_pkg::word_t    mem_wdata,
    output isa_pkg::word_t    rs_val,
    output isa_pkg::word_t    rt_val,
    output logic              stall_req
);

    isa_pkg::word_t regs [`ID_NREGS];
    logic           rs_hit;
    logic           rt_hit;

    // r0 is never stored
    always_ff @(posedge clk) begin
        if (wb_we && wb_waddr != '0) begin
            regs[wb_waddr] <= wb_wdata;
        end
    end

    // youngest producer wins
    function automatic isa_pkg::word_t read_port(isa_pkg::reg_idx_t idx);
        isa_pkg::word_t val;
        if (idx == '0) begin
            val = '0;
        end else if (ex_we && ex_waddr == idx) begin
            val = ex_wdata;
        end else if (mem_we && mem_waddr == idx) begin
            val = mem_wdata;
        end else if (wb_we && wb_waddr == idx) begin
            val = wb_wdata;
        end else begin
            val = regs[idx];
        end
        return val;
    endfunction

    always_comb begin
        rs_val = read_port(rs);
        rt_val = read_port(rt);
    end

    // load in ex cannot forward yet
    assign rs_hit    = uses_rs && rs == ex_waddr;
    assign rt_hit    = uses_rt && rt == ex_waddr;
    assign stall_req = id_valid && ex_is_load && ex_we && ex_waddr != '0 && (rs_hit || rt_hit);

    // the decoder drops operand use for a bubble
    a_no_use_when_idle: assert property (@(posedge clk) disable iff (rst)
        !id_valid |-> !(uses_rs || uses_rt));

endmodule

// ==== hw/branch_unit.sv ====
module branch_unit (
    input  logic               id_valid,
    input  ctrl_pkg::br_kind_e br_kind,
    input  isa_pkg::word_t     id_pc,
    input  isa_pkg::word_t     id_inst,
    input  isa_pkg::word_t     rs_val,
    input  isa_pkg::word_t     rt_val,
    output logic               br_taken,
    output isa_pkg::word_t     br_target
);

    isa_pkg::word_t pc_plus4;
    isa_pkg::imm16_t offset;
    isa_pkg::jidx_t index;
    isa_pkg::word_t br_off;
    logic           taken;

    assign pc_plus4 = id_pc + isa_pkg::word_t'(4);
    assign offset   = id_inst[15:0];
    assign index    = id_inst[25:0];
    assign br_off   = {{14{offset[15]}}, offset, 2'b00};

    always_comb begin
        taken     = 1'b0;
        br_target = pc_plus4;
        case (br_kind)
            ctrl_pkg::BR_BEQ: begin
                taken     = (rs_val == rt_val);
                br_target = pc_plus4 + br_off;
            end
            ctrl_pkg::BR_BNE: begin
                taken     = (rs_val != rt_val);
                br_target = pc_plus4 + br_off;
            end
            // region of the delay slot
            ctrl_pkg::BR_JUMP: begin
                taken     = 1'b1;
                br_target = {pc_plus4[31:28], index, 2'b00};
            end
            ctrl_pkg::BR_JR: begin
                taken     = 1'b1;
                br_target = rs_val;
            end
            default: ;
        endcase
    end

    assign br_taken = id_valid & taken;

    // targets built from the pc stay word aligned
    always_comb begin
        a_target_aligned: assert (!br_taken || br_kind == ctrl_pkg::BR_JR
                                  || br_target[1:0] == 2'b00)
            else $error("branch target not word aligned");
    end

endmodule

// ==== hw/id_stage.sv ====
module id_stage (
    input  logic                clk,
    input  logic                rst,
    input  isa_pkg::word_t      fetch_pc,
    input  logic                fetch_valid,
    input  isa_pkg::word_t      inst_rdata,
    input  logic                hold_id,
    input  logic                bubble_id,
    input  logic                wb_we,
    input  isa_pkg::reg_idx_t   wb_waddr,
    input  isa_pkg::word_t      wb_wdata,
    input  logic                ex_we,
    input  isa_pkg::reg_idx_t   ex_waddr,
    input  isa_pkg::word_t      ex_wdata,
    input  logic                ex_is_load,
    input  logic                mem_we,
    input  isa_pkg::reg_idx_t   mem_waddr,
    input  isa_pkg::word_t      mem_wdata,
    output logic                ex_valid,
    output isa_pkg::word_t      ex_pc,
    output isa_pkg::word_t      ex_inst,
    output ctrl_pkg::alu_op_e   ex_alu_op,
    output ctrl_pkg::src1_sel_e ex_src1_sel,
    output ctrl_pkg::src2_sel_e ex_src2_sel,
    output logic                ex_mem_en,
    output logic                ex_mem_we,
    output logic                ex_rf_we,
    output isa_pkg::reg_idx_t   ex_rf_waddr,
    output isa_pkg::word_t      ex_rs_val,
    output isa_pkg::word_t      ex_rt_val,
    output logic                br_taken,
    output isa_pkg::word_t      br_target,
    output logic                stall_req
);

    isa_pkg::reg_idx_t  rs;
    isa_pkg::reg_idx_t  rt;
    logic               uses_rs;
    logic               uses_rt;
    ctrl_pkg::br_kind_e br_kind;

    fetch_decode_reg i_fdr (
        .clk         (clk),
        .rst         (rst),
        .hold_id     (hold_id),
        .bubble_id   (bubble_id),
        .fetch_valid (fetch_valid),
        .fetch_pc    (fetch_pc),
        .inst_rdata  (inst_rdata),
        .id_valid    (ex_valid),
        .id_pc       (ex_pc),
        .id_inst     (ex_inst)
    );

    inst_decoder i_dec (
        .id_valid (ex_valid),
        .id_inst  (ex_inst),
        .rs       (rs),
        .rt       (rt),
        .alu_op   (ex_alu_op),
        .src1_sel (ex_src1_sel),
        .src2_sel (ex_src2_sel),
        .mem_en   (ex_mem_en),
        .mem_we   (ex_mem_we),
        .rf_we    (ex_rf_we),
        .rf_waddr (ex_rf_waddr),
        .br_kind  (br_kind),
        .uses_rs  (uses_rs),
        .uses_rt  (uses_rt)
    );

    operand_fetch i_opf (
        .clk        (clk),
        .rst        (rst),
        .rs         (rs),
        .rt         (rt),
        .uses_rs    (uses_rs),
        .uses_rt    (uses_rt),
        .id_valid   (ex_valid),
        .wb_we      (wb_we),
        .ex_we      (ex_we),
        .mem_we     (mem_we),
        .ex_is_load (ex_is_load),
        .wb_waddr   (wb_waddr),
        .ex_waddr   (ex_waddr),
        .mem_waddr  (mem_waddr),
        .wb_wdata   (wb_wdata),
        .ex_wdata   (ex_wdata),
        .mem_wdata  (mem_wdata),
        .rs_val     (ex_rs_val),
        .rt_val     (ex_rt_val),
        .stall_req  (stall_req)
    );

    branch_unit i_br (
        .id_valid  (ex_valid),
        .br_kind   (br_kind),
        .id_pc     (ex_pc),
        .id_inst   (ex_inst),
        .rs_val    (ex_rs_val),
        .rt_val    (ex_rt_val),
        .br_taken  (br_taken),
        .br_target (br_target)
    );

endmodule

// ==== test/tb_id_stage.sv ====
`include "id_settings.svh"

module tb_id_stage;

    localparam int N_CYCLES  = 3000;
    localparam int N_INIT    = `ID_NREGS - 1;
    localparam int RUN_LIMIT = (8 + N_INIT + N_CYCLES + 4) * 10 + 500;

    logic                clk;
    logic                rst;
    isa_pkg::word_t      fetch_pc;
    logic                fetch_valid;
    isa_pkg::word_t      inst_rdata = '0;
    logic                hold_id;
    logic                bubble_id;
    logic                wb_we;
    isa_pkg::reg_idx_t   wb_waddr;
    isa_pkg::word_t      wb_wdata;
    logic                ex_we;
    isa_pkg::reg_idx_t   ex_waddr;
    isa_pkg::word_t      ex_wdata;
    logic                ex_is_load;
    logic                mem_we;
    isa_pkg::reg_idx_t   mem_waddr;
    isa_pkg::word_t      mem_wdata;
    logic                ex_valid;
    isa_pkg::word_t      ex_pc;
    isa_pkg::word_t      ex_inst;
    ctrl_pkg::alu_op_e   ex_alu_op;
    ctrl_pkg::src1_sel_e ex_src1_sel;
    ctrl_pkg::src2_sel_e ex_src2_sel;
    logic                ex_mem_en;
    logic                ex_mem_we;
    logic                ex_rf_we;
    isa_pkg::reg_idx_t   ex_rf_waddr;
    isa_pkg::word_t      ex_rs_val;
    isa_pkg::word_t      ex_rt_val;
    logic                br_taken;
    isa_pkg::word_t      br_target;
    logic                stall_req;

    isa_pkg::word_t      imem [256];
    isa_pkg::word_t      shadow [`ID_NREGS];
    logic                m_valid;
    isa_pkg::word_t      m_pc;
    isa_pkg::word_t      m_inst;
    int                  errors = 0;

    logic [5:0]          m_op;
    logic [5:0]          m_fn;
    logic [4:0]          m_rs;
    logic [4:0]          m_rt;
    logic [4:0]          m_rd;
    logic [4:0]          m_sa;
    ctrl_pkg::alu_op_e   e_alu;
    ctrl_pkg::src1_sel_e e_s1;
    ctrl_pkg::src2_sel_e e_s2;
    logic                e_mem_en;
    logic                e_mem_we;
    logic                e_rf_we;
    isa_pkg::reg_idx_t   e_waddr;
    logic                e_uses_rs;
    logic                e_uses_rt;
    logic                e_beq;
    logic                e_bne;
    logic                e_jmp;
    logic                e_jr;
    isa_pkg::word_t      e_rs;
    isa_pkg::word_t      e_rt;
    logic                e_stall;
    logic                e_taken;
    isa_pkg::word_t      e_pc4;
    isa_pkg::word_t      e_target;

    id_stage i_dut (
        .clk(clk), .rst(rst), .fetch_pc(fetch_pc), .fetch_valid(fetch_valid),
        .inst_rdata(inst_rdata), .hold_id(hold_id), .bubble_id(bubble_id),
        .wb_we(wb_we), .wb_waddr(wb_waddr), .wb_wdata(wb_wdata),
        .ex_we(ex_we), .ex_waddr(ex_waddr), .ex_wdata(ex_wdata), .ex_is_load(ex_is_load),
        .mem_we(mem_we), .mem_waddr(mem_waddr), .mem_wdata(mem_wdata),
        .ex_valid(ex_valid), .ex_pc(ex_pc), .ex_inst(ex_inst), .ex_alu_op(ex_alu_op),
        .ex_src1_sel(ex_src1_sel), .ex_src2_sel(ex_src2_sel), .ex_mem_en(ex_mem_en),
        .ex_mem_we(ex_mem_we), .ex_rf_we(ex_rf_we), .ex_rf_waddr(ex_rf_waddr),
        .ex_rs_val(ex_rs_val), .ex_rt_val(ex_rt_val), .br_taken(br_taken),
        .br_target(br_target), .stall_req(stall_req)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic report_error(string msg);
        errors++;
        $display("Error at %0t: %s", $time, msg);
    endtask

    function automatic isa_pkg::word_t make_inst(int kind);
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [4:0]  rd;
        logic [15:0] imm;
        isa_pkg::word_t w;
        rs  = 5'($urandom % 8);
        rt  = 5'($urandom % 8);
        rd  = 5'($urandom % 8);
        imm = 16'($urandom);
        case (kind)
            0:  w = {6'h00, rs, rt, rd, 5'd0, 6'h21};
            1:  w = {6'h00, rs, rt, rd, 5'd0, 6'h23};
            2:  w = {6'h00, rs, rt, rd, 5'd0, 6'h24};
            3:  w = {6'h00, rs, rt, rd, 5'd0, 6'h25};
            4:  w = {6'h00, rs, rt, rd, 5'd0, 6'h26};
            5:  w = {6'h00, rs, rt, rd, 5'd0, 6'h27};
            6:  w = {6'h00, rs, rt, rd, 5'd0, 6'h2a};
            7:  w = {6'h00, rs, rt, rd, 5'd0, 6'h2b};
            8:  w = {6'h00, 5'd0, rt, rd, imm[4:0], 6'h00};
            9:  w = {6'h00, 5'd0, rt, rd, imm[4:0], 6'h02};
            10: w = {6'h00, 5'd0, rt, rd, imm[4:0], 6'h03};
            11: w = {6'h09, rs, rt, imm};
            12: w = {6'h0a, rs, rt, imm};
            13: w = {6'h0b, rs, rt, imm};
            14: w = {6'h0c, rs, rt, imm};
            15: w = {6'h0d, rs, rt, imm};
            16: w = {6'h0e, rs, rt, imm};
            17: w = {6'h0f, 5'd0, rt, imm};
            18: w = {6'h23, rs, rt, imm};
            19: w = {6'h2b, rs, rt, imm};
            20: w = {6'h04, rs, rt, imm};
            21: w = {6'h05, rs, rt, imm};
            22: w = {6'h02, 26'($urandom)};
            23: w = {6'h03, 26'($urandom)};
            24: w = {6'h00, rs, 15'd0, 6'h08};
            default: w = $urandom;
        endcase
        return w;
    endfunction

    // ALU operation by opcode, or by funct for special
    function automatic ctrl_pkg::alu_op_e alu_op_for(logic [5:0] op, logic [5:0] fn);
        if (op == 6'h00) begin
            case (fn)
                6'h23: return ctrl_pkg::ALU_SUB;
                6'h24: return ctrl_pkg::ALU_AND;
                6'h25: return ctrl_pkg::ALU_OR;
                6'h26: return ctrl_pkg::ALU_XOR;
                6'h27: return ctrl_pkg::ALU_NOR;
                6'h2a: return ctrl_pkg::ALU_SLT;
                6'h2b: return ctrl_pkg::ALU_SLTU;
                6'h00: return ctrl_pkg::ALU_SLL;
                6'h02: return ctrl_pkg::ALU_SRL;
                6'h03: return ctrl_pkg::ALU_SRA;
                default: return ctrl_pkg::ALU_ADD;
            endcase
        end
        case (op)
            6'h0a: return ctrl_pkg::ALU_SLT;
            6'h0b: return ctrl_pkg::ALU_SLTU;
            6'h0c: return ctrl_pkg::ALU_AND;
            6'h0d: return ctrl_pkg::ALU_OR;
            6'h0e: return ctrl_pkg::ALU_XOR;
            6'h0f: return ctrl_pkg::ALU_LUI;
            default: return ctrl_pkg::ALU_ADD;
        endcase
    endfunction

    // newest write in flight wins, r0 stays zero
    function automatic isa_pkg::word_t forward_value(isa_pkg::reg_idx_t idx);
        if (idx == '0) return '0;
        if (ex_we && ex_waddr == idx) return ex_wdata;
        if (mem_we && mem_waddr == idx) return mem_wdata;
        if (wb_we && wb_waddr == idx) return wb_wdata;
        return shadow[idx];
    endfunction

    task automatic drive_random_cycle();
        fetch_valid = ($urandom % 10) < 8;
        fetch_pc    = {22'($urandom), 8'($urandom), 2'b00};
        hold_id     = ($urandom % 10) < 2;
        bubble_id   = !hold_id && (($urandom % 10) == 0);
        wb_we       = ($urandom % 2) == 0;
        wb_waddr    = 5'($urandom % 8);
        wb_wdata    = $urandom;
        ex_we       = ($urandom % 10) < 6;
        ex_waddr    = 5'($urandom % 8);
        ex_wdata    = $urandom;
        ex_is_load  = ($urandom % 10) < 4;
        mem_we      = ($urandom % 2) == 0;
        mem_waddr   = 5'($urandom % 8);
        mem_wdata   = $urandom;
    endtask

    // synchronous instruction memory
    always @(posedge clk) begin
        inst_rdata <= imem[fetch_pc[9:2]];
    end

    // model of the decode register
    always @(posedge clk) begin
        if (rst) begin
            m_valid <= 1'b0;
        end else if (!hold_id) begin
            m_valid <= fetch_valid && !bubble_id;
            m_pc    <= fetch_pc;
            m_inst  <= imem[fetch_pc[9:2]];
        end
    end

    always @(posedge clk) begin
        if (wb_we && wb_waddr != '0) begin
            shadow[wb_waddr] <= wb_wdata;
        end
    end

    assign m_op = m_inst[31:26];
    assign m_fn = m_inst[5:0];
    assign m_rs = m_inst[25:21];
    assign m_rt = m_inst[20:16];
    assign m_rd = m_inst[15:11];
    assign m_sa = m_inst[10:6];

    always_comb begin
        e_alu     = alu_op_for(m_op, m_fn);
        e_s1      = ctrl_pkg::SRC1_RS;
        e_s2      = ctrl_pkg::SRC2_RT;
        e_mem_en  = 1'b0;
        e_mem_we  = 1'b0;
        e_rf_we   = 1'b0;
        e_waddr   = '0;
        e_uses_rs = 1'b0;
        e_uses_rt = 1'b0;
        e_beq     = 1'b0;
        e_bne     = 1'b0;
        e_jmp     = 1'b0;
        e_jr      = 1'b0;
        case (m_op)
            6'h00: begin
                case (m_fn)
                    6'h21, 6'h23, 6'h24, 6'h25, 6'h26, 6'h27, 6'h2a, 6'h2b: begin
                        e_rf_we   = (m_sa == 5'd0);
                        e_uses_rs = (m_sa == 5'd0);
                        e_uses_rt = (m_sa == 5'd0);
                    end
                    6'h00, 6'h02, 6'h03: begin
                        e_rf_we   = (m_rs == 5'd0);
                        e_uses_rt = (m_rs == 5'd0);
                        e_s1      = ctrl_pkg::SRC1_SA;
                    end
                    6'h08: begin
                        e_jr      = (m_inst[20:6] == 15'd0);
                        e_uses_rs = e_jr;
                    end
                    default: ;
                endcase
                e_waddr = m_rd;
            end
            6'h09, 6'h0a, 6'h0b, 6'h0c, 6'h0d, 6'h0e, 6'h0f, 6'h23: begin
                e_rf_we   = 1'b1;
                e_waddr   = m_rt;
                e_uses_rs = (m_op != 6'h0f);
                e_mem_en  = (m_op == 6'h23);
                e_s2      = (m_op >= 6'h0c && m_op <= 6'h0e) ? ctrl_pkg::SRC2_ZIMM
                                                              : ctrl_pkg::SRC2_SIMM;
            end
            6'h2b: begin
                e_mem_en  = 1'b1;
                e_mem_we  = 1'b1;
                e_s2      = ctrl_pkg::SRC2_SIMM;
                e_uses_rs = 1'b1;
                e_uses_rt = 1'b1;
            end
            6'h04, 6'h05: begin
                e_beq     = (m_op == 6'h04);
                e_bne     = (m_op == 6'h05);
                e_uses_rs = 1'b1;
                e_uses_rt = 1'b1;
            end
            6'h02: e_jmp = 1'b1;
            6'h03: begin
                e_jmp   = 1'b1;
                e_rf_we = 1'b1;
                e_waddr = 5'(`ID_LINK_REG);
                e_s1    = ctrl_pkg::SRC1_PC;
                e_s2    = ctrl_pkg::SRC2_EIGHT;
            end
            default: ;
        endcase
    end

    always_comb begin
        e_rs = forward_value(m_rs);
        e_rt = forward_value(m_rt);
    end

    assign e_stall = m_valid && ex_is_load && ex_we && ex_waddr != '0
                     && ((e_uses_rs && m_rs == ex_waddr) || (e_uses_rt && m_rt == ex_waddr));
    assign e_taken = m_valid && (e_jmp || e_jr || (e_beq && e_rs == e_rt)
                     || (e_bne && e_rs != e_rt));
    assign e_pc4    = m_pc + 32'd4;
    assign e_target = e_jr ? e_rs
                    : e_jmp ? {e_pc4[31:28], m_inst[25:0], 2'b00}
                    : e_pc4 + {{14{m_inst[15]}}, m_inst[15:0], 2'b00};

    a_idle: assert property (@(posedge clk) disable iff (rst)
        !ex_valid |-> !(ex_rf_we || ex_mem_en || ex_mem_we || br_taken || stall_req))
        else report_error("control output active without a valid instruction");

    a_decode_reg: assert property (@(posedge clk) disable iff (rst)
        ex_valid == m_valid && (!m_valid || (ex_pc == m_pc && ex_inst == m_inst)))
        else report_error("decode register valid, pc or instruction wrong");

    a_decode: assert property (@(posedge clk) disable iff (rst)
        m_valid |-> ex_rf_we == e_rf_we && ex_mem_en == e_mem_en && ex_mem_we == e_mem_we
            && (!e_rf_we || ex_rf_waddr == e_waddr)
            && (!(e_rf_we || e_mem_en) || (ex_alu_op == e_alu && ex_src1_sel == e_s1
                && ex_src2_sel == e_s2)))
        else report_error("decoded control bundle wrong");

    a_operands: assert property (@(posedge clk) disable iff (rst)
        m_valid |-> ex_rs_val == e_rs && ex_rt_val == e_rt)
        else report_error("operand value wrong");

    a_stall: assert property (@(posedge clk) disable iff (rst) stall_req == e_stall)
        else report_error("stall_req does not follow the load-use rule");

    a_branch: assert property (@(posedge clk) disable iff (rst)
        br_taken == e_taken && (!e_taken || br_target == e_target))
        else report_error("branch decision or target wrong");

    a_hold: assert property (@(posedge clk) disable iff (rst)
        hold_id |=> $stable(ex_valid) && $stable(ex_pc) && $stable(ex_inst))
        else report_error("decode register moved under hold");

    a_bubble: assert property (@(posedge clk) disable iff (rst)
        bubble_id && !hold_id |=> !ex_valid)
        else report_error("valid instruction after a bubble");

    initial begin
        #(RUN_LIMIT);
        $display("timeout: the run did not finish within %0d time units", RUN_LIMIT);
        $display("TB FAILED");
        $finish;
    end

    initial begin
        void'($urandom(32'h603fcbbf));
        rst         = 1'b1;
        fetch_pc    = '0;
        fetch_valid = 1'b0;
        hold_id     = 1'b0;
        bubble_id   = 1'b0;
        wb_we       = 1'b0;
        wb_waddr    = '0;
        wb_wdata    = '0;
        ex_we       = 1'b0;
        ex_waddr    = '0;
        ex_wdata    = '0;
        ex_is_load  = 1'b0;
        mem_we      = 1'b0;
        mem_waddr   = '0;
        mem_wdata   = '0;
        for (int i = 0; i < 256; i++) begin
            imem[i] = make_inst(int'($urandom % 26));
        end
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        // fill the register file with no fetch in flight
        for (int r = 1; r <= N_INIT; r++) begin
            @(negedge clk);
            wb_we    = 1'b1;
            wb_waddr = 5'(r);
            wb_wdata = $urandom;
        end
        @(negedge clk);
        wb_we = 1'b0;
        for (int c = 0; c < N_CYCLES; c++) begin
            @(negedge clk);
            drive_random_cycle();
        end
        @(negedge clk);
        fetch_valid = 1'b0;
        hold_id     = 1'b0;
        bubble_id   = 1'b0;
        repeat (2) @(negedge clk);
        $display("cycles: %0d, errors: %0d", N_CYCLES, errors);
        if (errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

// ==== tb.f ====
+incdir+hw
hw/isa_pkg.sv
hw/ctrl_pkg.sv
hw/fetch_decode_reg.sv
hw/inst_decoder.sv
hw/operand_fetch.sv
hw/branch_unit.sv
hw/id_stage.sv
test/tb_id_stage.sv

// ==== Makefile ====
SRCS := $(filter-out +%,$(shell cat tb.f)) hw/id_settings.svh

all: run

obj_dir/Vtb_id_stage: tb.f $(SRCS)
	verilator --binary --timing --assert --top-module tb_id_stage -f tb.f -o Vtb_id_stage

run: obj_dir/Vtb_id_stage
	obj_dir/Vtb_id_stage | tee sim.log
	grep -q "^TB PASSED$$" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: all run clean
